// ==== source/alu.sv ====
`timescale 1ns/10ps

module alu import bus_pkg::*, isa_pkg::*;
(
    input  instr_t   instr,
    input  word_t    ra_data,
    input  word_t    rb_data,
    input  logic     ra_flag,
    output alu_out_t result
);

    always_comb
    begin
        result = '0;
        case (instr.opcode)
            ADD:
            begin
                result.result = ra_data + rb_data;
            end
            SUB:
            begin
                result.result = ra_data - rb_data;   // Wraps modulo 2^32
            end
            AND:
            begin
                result.result = ra_data & rb_data;
            end
            OR:
            begin
                result.result = ra_data | rb_data;
            end
            XOR:
            begin
                result.result = ra_data ^ rb_data;
            end
            LDI:
            begin
                result.result = word_t'(instr.imm);   // Zero extend
            end
            CMPEQ:
            begin
                result.flag = (ra_data == rb_data);
            end
            CMPLT:
            begin
                result.flag = (ra_data < rb_data);    // Unsigned
            end
            BRF:
            begin
                result.branch_taken = ra_flag;
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    localparam int WORD_W    = 32;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 256;   // Words, program and data share it

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Processor port request
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // External load and peek port request
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } load_req_t;

endpackage

// ==== source/cpu_control.sv ====
`timescale 1ns/10ps

module cpu_control import bus_pkg::*, isa_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  word_t    mem_rdata,
    input  alu_out_t alu_res,
    input  word_t    ra_data,
    output mem_req_t mem_req,
    output instr_t   instr,
    output reg_idx_t ra_idx,
    output reg_idx_t rb_idx,
    output reg_idx_t wd_idx,
    output logic     reg_we,
    output logic     flag_we,
    output word_t    reg_wdata,
    output logic     flag_wdata,
    output logic     halted
);

    typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEM_WAIT, HALTED} ctrl_state_e;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    addr_t       pc;
    addr_t       pc_nxt;
    addr_t       pc_inc;
    addr_t       imm_addr;
    instr_t      ir;

    assign pc_inc   = pc + addr_t'(1);
    assign imm_addr = ir.imm[ADDR_W-1:0];   // Word address from the low imm bits

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= FETCH;
            pc    <= '0;
            ir    <= '0;
        end
        else
        begin
            state <= state_nxt;
            pc    <= pc_nxt;
            if (state == DECODE)
                ir <= instr_t'(mem_rdata);   // Fetched word arrives here
        end
    end

    always_comb
    begin
        state_nxt = state;
        pc_nxt    = pc;
        mem_req   = '0;
        reg_we    = 1'b0;
        flag_we   = 1'b0;
        case (state)
            FETCH:
            begin
                mem_req.valid = 1'b1;
                mem_req.addr  = pc;
                state_nxt     = DECODE;
            end
            DECODE:
            begin
                state_nxt = EXECUTE;
            end
            EXECUTE:
            begin
                state_nxt = FETCH;
                case (ir.opcode)
                    ADD, SUB, AND, OR, XOR, LDI:
                    begin
                        reg_we = 1'b1;
                        pc_nxt = pc_inc;
                    end
                    CMPEQ, CMPLT:
                    begin
                        flag_we = 1'b1;
                        pc_nxt  = pc_inc;
                    end
                    STORE:
                    begin
                        mem_req = '{valid: 1'b1, write: 1'b1, addr: imm_addr, wdata: ra_data};
                        pc_nxt  = pc_inc;
                    end
                    LOAD:
                    begin
                        mem_req.valid = 1'b1;
                        mem_req.addr  = imm_addr;
                        pc_nxt        = pc_inc;
                        state_nxt     = MEM_WAIT;   // Data returns next cycle
                    end
                    JMP:
                    begin
                        pc_nxt = imm_addr;
                    end
                    BRF:
                    begin
                        pc_nxt = alu_res.branch_taken ? imm_addr : pc_inc;
                    end
                    HALT:
                    begin
                        state_nxt = HALTED;   // pc stays on the HALT
                    end
                    default:
                    begin
                        pc_nxt = pc_inc;
                    end
                endcase
            end
            MEM_WAIT:
            begin
                reg_we    = 1'b1;
                state_nxt = FETCH;
            end
            HALTED:
            begin
                state_nxt = HALTED;   // Only reset leaves
            end
            default:
            begin
                state_nxt = FETCH;
            end
        endcase
    end

    assign instr      = ir;
    assign ra_idx     = ir.ra;
    assign rb_idx     = ir.rb;
    assign wd_idx     = ir.rd;
    assign reg_wdata  = (state == MEM_WAIT) ? mem_rdata : alu_res.result;
    assign flag_wdata = alu_res.flag;
    assign halted     = (state == HALTED);

endmodule

// ==== source/cpu_system.sv ====
`timescale 1ns/10ps

module cpu_system import bus_pkg::*, isa_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  load_req_t load_req,
    output word_t     peek_data,
    output logic      halted
);

    mem_req_t cpu_req;
    word_t    mem_rdata;
    instr_t   instr;
    alu_out_t alu_res;
    reg_idx_t ra_idx;
    reg_idx_t rb_idx;
    reg_idx_t wd_idx;
    logic     reg_we;
    logic     flag_we;
    word_t    reg_wdata;
    logic     flag_wdata;
    word_t    ra_data;
    word_t    rb_data;
    logic     ra_flag;

    cpu_control u_control (
        .clock      (clock),
        .rst_n      (rst_n),
        .mem_rdata  (mem_rdata),
        .alu_res    (alu_res),
        .ra_data    (ra_data),
        .mem_req    (cpu_req),
        .instr      (instr),
        .ra_idx     (ra_idx),
        .rb_idx     (rb_idx),
        .wd_idx     (wd_idx),
        .reg_we     (reg_we),
        .flag_we    (flag_we),
        .reg_wdata  (reg_wdata),
        .flag_wdata (flag_wdata),
        .halted     (halted)
    );

    reg_file u_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .ra_idx     (ra_idx),
        .rb_idx     (rb_idx),
        .wd_idx     (wd_idx),
        .reg_we     (reg_we),
        .flag_we    (flag_we),
        .reg_wdata  (reg_wdata),
        .flag_wdata (flag_wdata),
        .ra_data    (ra_data),
        .rb_data    (rb_data),
        .ra_flag    (ra_flag),
        .rb_flag    ()            // No consumer of the second flag
    );

    alu u_alu (
        .instr   (instr),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .ra_flag (ra_flag),
        .result  (alu_res)
    );

    word_mem u_mem (
        .clock     (clock),
        .cpu_req   (cpu_req),
        .cpu_rdata (mem_rdata),
        .ext_req   (load_req),
        .ext_rdata (peek_data)
    );

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

    import bus_pkg::*;

    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;
    localparam int OPCODE_W  = 4;
    localparam int IMM_W     = 16;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [OPCODE_W-1:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        LDI,     // rd = zero-extended imm
        CMPEQ,   // flag[rd] = ra == rb
        CMPLT,   // flag[rd] = ra < rb, unsigned
        LOAD,    // rd = mem[imm]
        STORE,   // mem[imm] = ra
        JMP,
        BRF,     // Branch to imm when flag[ra] is set
        HALT
    } opcode_e;

    // Instruction word, opcode in the top nibble
    typedef struct packed {
        opcode_e          opcode;
        reg_idx_t         rd;
        reg_idx_t         ra;
        reg_idx_t         rb;
        logic [2:0]       unused;
        logic [IMM_W-1:0] imm;
    } instr_t;

    typedef struct packed {
        word_t result;
        logic  flag;
        logic  branch_taken;
    } alu_out_t;

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import bus_pkg::*, isa_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t ra_idx,
    input  reg_idx_t rb_idx,
    input  reg_idx_t wd_idx,
    input  logic     reg_we,
    input  logic     flag_we,
    input  word_t    reg_wdata,
    input  logic     flag_wdata,
    output word_t    ra_data,
    output word_t    rb_data,
    output logic     ra_flag,
    output logic     rb_flag
);

    word_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] flags;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (reg_we)
        begin
            regs[wd_idx] <= reg_wdata;
        end
    end

    // Flags are written independently of the word registers
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flags <= '0;
        end
        else if (flag_we)
        begin
            flags[wd_idx] <= flag_wdata;
        end
    end

    assign ra_data = regs[ra_idx];    // Combinational read ports
    assign rb_data = regs[rb_idx];
    assign ra_flag = flags[ra_idx];
    assign rb_flag = flags[rb_idx];

endmodule

// ==== source/word_mem.sv ====
`timescale 1ns/10ps

module word_mem import bus_pkg::*;
(
    input  logic      clock,
    input  mem_req_t  cpu_req,
    output word_t     cpu_rdata,
    input  load_req_t ext_req,
    output word_t     ext_rdata
);

    word_t mem [MEM_DEPTH];

    // Port B write first so a port A write to the same word lands last
    always_ff @(posedge clock)
    begin
        if (ext_req.valid && ext_req.write)
            mem[ext_req.addr] <= ext_req.wdata;
        if (cpu_req.valid && cpu_req.write)
            mem[cpu_req.addr] <= cpu_req.wdata;
    end

    // Processor read port
    always_ff @(posedge clock)
    begin
        if (cpu_req.valid && !cpu_req.write)
        begin
            cpu_rdata <= mem[cpu_req.addr];
        end
    end

    // External peek port
    always_ff @(posedge clock)
    begin
        if (ext_req.valid && !ext_req.write)
        begin
            ext_rdata <= mem[ext_req.addr];
        end
    end

endmodule

// ==== src.f ====
source/bus_pkg.sv
source/isa_pkg.sv
source/reg_file.sv
source/alu.sv
source/cpu_control.sv
source/word_mem.sv
source/cpu_system.sv
verif/cpu_system_asserts.sv
verif/cpu_system_tb.sv

// ==== verif/cpu_system_asserts.sv ====
`timescale 1ns/10ps

module cpu_system_asserts import bus_pkg::*;
(
    input logic       clock,
    input logic       rst_n,
    input logic [2:0] state,
    input mem_req_t   mem_req,
    input logic       halted
);

    localparam logic [2:0] ST_EXECUTE = 3'd2;
    localparam logic [2:0] ST_LAST    = 3'd4;   // HALTED is the highest encoding

    int unsigned fail_count = 0;

    state_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        state <= ST_LAST)
    else
    begin
        fail_count++;
        $error("Control state outside the defined encoding");
    end

    write_in_execute: assert property (@(posedge clock) disable iff (!rst_n)
        (mem_req.valid && mem_req.write) |-> (state == ST_EXECUTE))
    else
    begin
        fail_count++;
        $error("Memory write issued outside EXECUTE");
    end

    halted_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted)
    else
    begin
        fail_count++;
        $error("halted dropped without reset");
    end

endmodule

bind cpu_control cpu_system_asserts u_asserts (
    .clock   (clock),
    .rst_n   (rst_n),
    .state   (state),
    .mem_req (mem_req),
    .halted  (halted)
);

// ==== verif/cpu_system_tb.sv ====
`timescale 1ns/10ps

module cpu_system_tb import bus_pkg::*, isa_pkg::*;
();

    localparam int    CLK_PERIOD       = 20;
    localparam int    PROG_INSTR       = 61;   // Program words over all runs
    localparam int    CYCLES_PER_INSTR = 400;
    localparam word_t MARKER           = 32'h0000_beef;

    logic      clock;
    logic      rst_n;
    load_req_t load_req;
    word_t     peek_data;
    logic      halted;

    word_t rng = 32'd44;
    word_t prog [$];
    addr_t pre_addr [$];
    word_t pre_data [$];
    string test_name;
    int    run_cycles;

    cpu_system u_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .peek_data (peek_data),
        .halted    (halted)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic word_t xorshift32();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // Encodes one instruction and appends it to the program image
    function automatic void emit(opcode_e op, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb,
                                 logic [15:0] imm);
        instr_t ins;
        ins        = '0;
        ins.opcode = op;
        ins.rd     = rd;
        ins.ra     = ra;
        ins.rb     = rb;
        ins.imm    = imm;
        prog.push_back(word_t'(ins));
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic write_word(input addr_t addr, input word_t data);
        next_cycle();
        load_req = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
    endtask

    task automatic read_word(input addr_t addr, output word_t data);
        next_cycle();
        load_req = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
        next_cycle();
        load_req = '0;
        data     = peek_data;   // Peek data lands one edge after the request
    endtask

    task automatic expect_mem(input addr_t addr, input word_t exp);
        word_t act;
        read_word(addr, act);
        check_word($sformatf("%s mem[%h]", test_name, addr), exp, act);
    endtask

    task automatic new_program(input string name);
        test_name = name;
        prog.delete();
        pre_addr.delete();
        pre_data.delete();
    endtask

    task automatic preload(input addr_t addr, input word_t data);
        pre_addr.push_back(addr);
        pre_data.push_back(data);
    endtask

    // Loads program and data under reset, then runs until halted
    task automatic run_program();
        next_cycle();
        rst_n = 1'b0;
        foreach (prog[i])
            write_word(addr_t'(i), prog[i]);
        foreach (pre_addr[i])
            write_word(pre_addr[i], pre_data[i]);
        next_cycle();
        load_req = '0;
        repeat (3) next_cycle();
        rst_n      = 1'b1;
        run_cycles = 0;
        while (!halted)
        begin
            next_cycle();
            run_cycles++;
        end
    endtask

    task automatic test_alu_ops();
        word_t a;
        word_t b;
        a = xorshift32() & 32'h0000_ffff;   // LDI carries 16 bits
        b = xorshift32() & 32'h0000_ffff;
        new_program("alu_ops");
        emit(LDI, 1, 0, 0, a[15:0]);
        emit(LDI, 2, 0, 0, b[15:0]);
        emit(ADD, 3, 1, 2, 16'h0);
        emit(STORE, 0, 3, 0, 16'h80);
        emit(SUB, 3, 1, 2, 16'h0);
        emit(STORE, 0, 3, 0, 16'h81);
        emit(AND, 3, 1, 2, 16'h0);
        emit(STORE, 0, 3, 0, 16'h82);
        emit(OR, 3, 1, 2, 16'h0);
        emit(STORE, 0, 3, 0, 16'h83);
        emit(XOR, 3, 1, 2, 16'h0);
        emit(STORE, 0, 3, 0, 16'h84);
        emit(HALT, 0, 0, 0, 16'h0);
        run_program();
        expect_mem(8'h80, a + b);
        expect_mem(8'h81, a - b);
        expect_mem(8'h82, a & b);
        expect_mem(8'h83, a | b);
        expect_mem(8'h84, a ^ b);
    endtask

    task automatic test_load_store();
        word_t d [4];
        new_program("load_store");
        for (int i = 0; i < 4; i++)
        begin
            d[i] = xorshift32();
            preload(addr_t'(8'h40 + i), d[i]);
        end
        emit(LOAD, 1, 0, 0, 16'h40);
        emit(LOAD, 2, 0, 0, 16'h41);
        emit(ADD, 3, 1, 2, 16'h0);
        emit(STORE, 0, 3, 0, 16'h50);
        emit(LOAD, 1, 0, 0, 16'h42);
        emit(LOAD, 2, 0, 0, 16'h43);
        emit(ADD, 3, 1, 2, 16'h0);
        emit(STORE, 0, 3, 0, 16'h51);
        emit(HALT, 0, 0, 0, 16'h0);
        run_program();
        expect_mem(8'h50, d[0] + d[1]);
        expect_mem(8'h51, d[2] + d[3]);
    endtask

    // Each BRF skips its marker store when the tested flag is set
    task automatic test_compare_branch(input word_t x, input word_t y);
        new_program($sformatf("compare_branch %0d %0d", x, y));
        preload(8'h60, '0);
        preload(8'h61, '0);
        emit(LDI, 1, 0, 0, x[15:0]);
        emit(LDI, 2, 0, 0, y[15:0]);
        emit(CMPEQ, 4, 1, 2, 16'h0);
        emit(CMPLT, 5, 1, 2, 16'h0);
        emit(LDI, 6, 0, 0, MARKER[15:0]);
        emit(BRF, 0, 4, 0, 16'd7);
        emit(STORE, 0, 6, 0, 16'h60);
        emit(BRF, 0, 5, 0, 16'd9);
        emit(STORE, 0, 6, 0, 16'h61);
        emit(HALT, 0, 0, 0, 16'h0);
        run_program();
        expect_mem(8'h60, (x == y) ? word_t'(0) : MARKER);
        expect_mem(8'h61, (x < y) ? word_t'(0) : MARKER);
    endtask

    task automatic test_countdown_loop();
        word_t n;
        n = (xorshift32() % 13) + 1;
        new_program("countdown_loop");
        emit(LDI, 1, 0, 0, n[15:0]);       // Loop counter
        emit(LDI, 2, 0, 0, 16'd1);
        emit(LDI, 3, 0, 0, 16'd0);         // Iterations seen
        emit(LDI, 7, 0, 0, 16'd0);
        emit(CMPEQ, 4, 1, 7, 16'h0);
        emit(BRF, 0, 4, 0, 16'd9);
        emit(SUB, 1, 1, 2, 16'h0);
        emit(ADD, 3, 3, 2, 16'h0);
        emit(JMP, 0, 0, 0, 16'd4);
        emit(STORE, 0, 3, 0, 16'h70);
        emit(HALT, 0, 0, 0, 16'h0);
        run_program();
        expect_mem(8'h70, n);
    endtask

    task automatic halt_program(input string name, input logic [15:0] value);
        new_program(name);
        preload(8'h79, '0);
        emit(LDI, 1, 0, 0, value);
        emit(STORE, 0, 1, 0, 16'h78);
        emit(HALT, 0, 0, 0, 16'h0);
        emit(STORE, 0, 1, 0, 16'h79);     // Must never execute
    endtask

    task automatic test_halt_reset();
        halt_program("halt_reset", 16'h1234);
        run_program();
        check_word("halt_reset cycles to halt", word_t'(3 * 3), word_t'(run_cycles));
        repeat (10) next_cycle();
        check_flag("halt_reset still halted", 1'b1, halted);
        expect_mem(8'h78, 32'h0000_1234);
        expect_mem(8'h79, 32'h0);
        next_cycle();
        rst_n = 1'b0;
        #1;
        check_flag("halt_reset cleared", 1'b0, halted);
        halt_program("halt_reset rerun", 16'h5678);
        run_program();
        check_word("halt_reset rerun cycles to halt", word_t'(3 * 3), word_t'(run_cycles));
        expect_mem(8'h78, 32'h0000_5678);
        expect_mem(8'h79, 32'h0);
    endtask

    initial
    begin
        #(PROG_INSTR * CYCLES_PER_INSTR * CLK_PERIOD);
        $display("Timeout after %0d cycles, a program never reached HALT",
                 PROG_INSTR * CYCLES_PER_INSTR);
        $display("Errors found");
        $fatal(1);
    end

    initial
    begin
        rst_n    = 1'b0;
        load_req = '0;
        test_alu_ops();
        test_load_store();
        test_compare_branch(32'd5, 32'd9);
        test_compare_branch(32'd7, 32'd7);
        test_countdown_loop();
        test_halt_reset();
        if (u_dut.u_control.u_asserts.fail_count != 0)
        begin
            $display("%0d assertion failures in the control unit",
                     u_dut.u_control.u_asserts.fail_count);
            $display("Errors found");
            $fatal(1);
        end
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule
